// ==== fp_pkg.sv ====
`default_nettype none

package fp_pkg;

    // ======================================================================
    // Stream and frame field types
    // ======================================================================

    // One stream byte or a CRC value
    typedef logic [7:0]  byte_t;
    // Frame address, sent most significant byte first
    typedef logic [31:0] addr_t;
    // Frame status code
    typedef logic [7:0]  status_t;

    // Status codes reported per frame
    localparam status_t STATUS_OK        = 8'h00;
    localparam status_t STATUS_CRC_ERR   = 8'h01;
    localparam status_t STATUS_CMD_INV   = 8'h02;
    localparam status_t STATUS_LEN_RANGE = 8'h03;
    localparam status_t STATUS_TIMEOUT   = 8'h04;

    // Protocol constants
    localparam byte_t      SOF_BYTE = 8'hAA;
    localparam logic [3:0] OP_READ  = 4'h1;
    localparam logic [3:0] OP_WRITE = 4'h2;
    // x^8 + x^2 + x + 1, initial value zero
    localparam byte_t      CRC_POLY = 8'h07;

    // Parser FSM, shared so messages can name the states
    typedef enum logic [2:0] {
        IDLE, CMD, ADDR, DATA, CRC, VALIDATE, HOLD, ERROR
    } parse_state_e;

    // Decoded frame, first data byte in the low bits
    typedef struct packed {
        byte_t       cmd;
        addr_t       addr;
        logic [63:0] data;
    } frame_t;

    // ======================================================================
    // APB bus
    // ======================================================================

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register offsets
    localparam logic [7:0] REG_STATUS    = 8'h00;
    localparam logic [7:0] REG_CMD       = 8'h04;
    localparam logic [7:0] REG_ADDR      = 8'h08;
    localparam logic [7:0] REG_DATA_LO   = 8'h0C;
    localparam logic [7:0] REG_DATA_HI   = 8'h10;
    localparam logic [7:0] REG_ERR_COUNT = 8'h14;
    localparam logic [7:0] REG_CTRL      = 8'h18;

endpackage

`default_nettype wire

// ==== rx_fifo.sv ====
`default_nettype none

module rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic          clk,
    input  logic          rst,
    input  fp_pkg::byte_t wr_data,
    input  logic          wr_valid,
    output logic          wr_ready,
    output fp_pkg::byte_t rd_data,
    input  logic          rd_en,
    output logic          empty
);

    // Address width; pointers carry one extra wrap bit
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] PTR_ONE = 1;

    // Byte storage, no reset
    fp_pkg::byte_t mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_fire;
    // Set one cycle after reset, holds off the write side until then
    logic        live_q;

    // Same index, different wrap bit
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ready = live_q && !full;
    assign wr_fire  = wr_valid && wr_ready;

    // Head byte shown without a read
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (!rst) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    // Pointer update
    // read and write may share an edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== frame_parser.sv ====
`default_nettype none

module frame_parser #(
    parameter int MAX_DATA_BYTES = 8,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  fp_pkg::byte_t   fifo_data,
    input  logic            fifo_empty,
    output logic            fifo_rd_en,
    output fp_pkg::frame_t  frame,
    output logic            frame_valid,
    output logic            frame_done,
    output fp_pkg::status_t frame_status,
    input  logic            frame_consume
);

    localparam logic [3:0] MAX_LEN = 4'(MAX_DATA_BYTES);
    // Wide enough to hold TIMEOUT_CYCLES itself
    localparam int TW = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [TW-1:0] TMO_LAST = TW'(TIMEOUT_CYCLES - 1);
    localparam logic [TW-1:0] TMO_ONE  = 1;

    fp_pkg::parse_state_e state;

    // Assembled frame and CRC bytes
    fp_pkg::frame_t  frame_q;
    fp_pkg::byte_t   crc_q;
    fp_pkg::byte_t   rx_crc_q;
    fp_pkg::byte_t   crc_next;

    // Control
    logic [2:0]      byte_cnt;
    logic [3:0]      len_m1;
    logic [TW-1:0]   tmo_cnt;
    logic            waiting;
    logic            tmo_hit;
    fp_pkg::status_t err_q;
    fp_pkg::status_t cmd_status;
    fp_pkg::status_t crc_status;

    // ======================================================================
    // CRC-8, MSB first, one byte per call
    // ======================================================================

    function automatic fp_pkg::byte_t crc8_update(
        input fp_pkg::byte_t crc,
        input fp_pkg::byte_t data
    );
        fp_pkg::byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = {c[6:0], 1'b0} ^ fp_pkg::CRC_POLY;
            end else begin
                c = {c[6:0], 1'b0};
            end
        end
        return c;
    endfunction

    assign crc_next = crc8_update(crc_q, fifo_data);

    // States that consume bytes from the FIFO
    assign waiting = (state == fp_pkg::CMD) || (state == fp_pkg::ADDR) ||
                     (state == fp_pkg::DATA) || (state == fp_pkg::CRC);

    // Never a read in HOLD, VALIDATE or ERROR
    assign fifo_rd_en = !fifo_empty && (waiting || (state == fp_pkg::IDLE));

    // Reached on the TIMEOUT_CYCLES-th silent cycle
    assign tmo_hit = waiting && fifo_empty && (tmo_cnt == TMO_LAST);

    // Last data index from the length nibble
    assign len_m1 = frame_q.cmd[3:0] - 4'd1;

    // Opcode and length check on the byte in the CMD step
    always_comb begin
        cmd_status = fp_pkg::STATUS_OK;
        case (fifo_data[7:4])
            fp_pkg::OP_READ: begin
                if (fifo_data[3:0] != 4'd0) begin
                    cmd_status = fp_pkg::STATUS_LEN_RANGE;
                end
            end
            fp_pkg::OP_WRITE: begin
                if (fifo_data[3:0] > MAX_LEN) begin
                    cmd_status = fp_pkg::STATUS_LEN_RANGE;
                end
            end
            default: cmd_status = fp_pkg::STATUS_CMD_INV;
        endcase
    end

    assign crc_status = (rx_crc_q == crc_q) ? fp_pkg::STATUS_OK : fp_pkg::STATUS_CRC_ERR;

    // ======================================================================
    // FSM and timeout counter
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= fp_pkg::IDLE;
            byte_cnt <= '0;
            tmo_cnt  <= '0;
            err_q    <= fp_pkg::STATUS_OK;
        end else begin
            // Silence counter, cleared by any read
            if (fifo_rd_en || !waiting) begin
                tmo_cnt <= '0;
            end else begin
                tmo_cnt <= tmo_cnt + TMO_ONE;
            end

            case (state)
                fp_pkg::IDLE: begin
                    // Anything but SOF is dropped
                    if (fifo_rd_en && fifo_data == fp_pkg::SOF_BYTE) begin
                        state <= fp_pkg::CMD;
                    end
                end
                fp_pkg::CMD: begin
                    if (fifo_rd_en) begin
                        byte_cnt <= '0;
                        if (cmd_status != fp_pkg::STATUS_OK) begin
                            err_q <= cmd_status;
                            state <= fp_pkg::ERROR;
                        end else begin
                            state <= fp_pkg::ADDR;
                        end
                    end
                end
                fp_pkg::ADDR: begin
                    if (fifo_rd_en) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (byte_cnt == 3'd3) begin
                            byte_cnt <= '0;
                            // Zero length skips the data step
                            if (frame_q.cmd[3:0] == 4'd0) begin
                                state <= fp_pkg::CRC;
                            end else begin
                                state <= fp_pkg::DATA;
                            end
                        end
                    end
                end
                fp_pkg::DATA: begin
                    if (fifo_rd_en) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if ({1'b0, byte_cnt} == len_m1) begin
                            state <= fp_pkg::CRC;
                        end
                    end
                end
                fp_pkg::CRC: begin
                    if (fifo_rd_en) begin
                        state <= fp_pkg::VALIDATE;
                    end
                end
                fp_pkg::VALIDATE: begin
                    if (crc_status == fp_pkg::STATUS_OK) begin
                        state <= fp_pkg::HOLD;
                    end else begin
                        state <= fp_pkg::IDLE;
                    end
                end
                fp_pkg::HOLD: begin
                    if (frame_consume) begin
                        state <= fp_pkg::IDLE;
                    end
                end
                default: state <= fp_pkg::IDLE;
            endcase

            // Mid-frame silence overrides the byte steps
            if (tmo_hit) begin
                err_q <= fp_pkg::STATUS_TIMEOUT;
                state <= fp_pkg::ERROR;
            end
        end
    end

    // Payload capture, no reset
    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            case (state)
                fp_pkg::IDLE: begin
                    // Fresh frame starts with zero CRC and empty data
                    crc_q        <= '0;
                    frame_q.data <= '0;
                end
                fp_pkg::CMD: begin
                    frame_q.cmd <= fifo_data;
                    crc_q       <= crc_next;
                end
                fp_pkg::ADDR: begin
                    frame_q.addr <= {frame_q.addr[23:0], fifo_data};
                    crc_q        <= crc_next;
                end
                fp_pkg::DATA: begin
                    frame_q.data[{byte_cnt, 3'b000} +: 8] <= fifo_data;
                    crc_q                                  <= crc_next;
                end
                fp_pkg::CRC: rx_crc_q <= fifo_data;
                default: ;
            endcase
        end
    end

    // Frame outputs
    assign frame        = frame_q;
    assign frame_valid  = (state == fp_pkg::HOLD);
    // One pulse per finished frame, good or bad
    assign frame_done   = (state == fp_pkg::VALIDATE) || (state == fp_pkg::ERROR);
    assign frame_status = (state == fp_pkg::VALIDATE) ? crc_status : err_q;

endmodule

`default_nettype wire

// ==== frame_apb_regs.sv ====
`default_nettype none

module frame_apb_regs (
    input  logic             clk,
    input  logic             rst,
    input  fp_pkg::apb_req_t apb_req,
    output fp_pkg::apb_rsp_t apb_rsp,
    input  fp_pkg::frame_t   frame,
    input  logic             frame_valid,
    input  logic             frame_done,
    input  fp_pkg::status_t  frame_status,
    output logic             frame_consume,
    output logic             frame_irq
);

    // Access phase, no wait states
    logic access;
    logic wr_ctrl;
    logic hit;
    logic [31:0] rdata;

    fp_pkg::status_t last_status;
    logic [7:0]      err_cnt;
    logic            consume_q;

    assign access = apb_req.psel && apb_req.penable;

    // Consume only when a frame is waiting
    assign wr_ctrl = access && apb_req.pwrite && (apb_req.paddr == fp_pkg::REG_CTRL) &&
                     apb_req.pwdata[0] && frame_valid;

    // ======================================================================
    // Read decode
    // ======================================================================

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            fp_pkg::REG_STATUS:    rdata = {16'h0, last_status, 7'h0, frame_valid};
            fp_pkg::REG_CMD:       rdata = {24'h0, frame.cmd};
            fp_pkg::REG_ADDR:      rdata = frame.addr;
            fp_pkg::REG_DATA_LO:   rdata = frame.data[31:0];
            fp_pkg::REG_DATA_HI:   rdata = frame.data[63:32];
            fp_pkg::REG_ERR_COUNT: rdata = {24'h0, err_cnt};
            // Write-only control, reads as zero
            fp_pkg::REG_CTRL:      rdata = '0;
            default:               hit   = 1'b0;
        endcase
    end

    // Unmapped offsets flag an error and do nothing else
    assign apb_rsp = '{
        prdata:  rdata,
        pready:  1'b1,
        pslverr: access && !hit
    };

    // ======================================================================
    // Status, error count and consume
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_status <= fp_pkg::STATUS_OK;
            err_cnt     <= '0;
            consume_q   <= 1'b0;
        end else begin
            // One-cycle pulse to the parser
            consume_q <= wr_ctrl;
            if (frame_done) begin
                last_status <= frame_status;
                // Saturates at 255
                if (frame_status != fp_pkg::STATUS_OK && err_cnt != 8'hFF) begin
                    err_cnt <= err_cnt + 8'd1;
                end
            end
        end
    end

    assign frame_consume = consume_q;

    // Interrupt while a good frame waits
    assign frame_irq = frame_valid;

endmodule

`default_nettype wire

// ==== frame_rx_top.sv ====
`default_nettype none

module frame_rx_top #(
    parameter int FIFO_DEPTH     = 16,
    parameter int MAX_DATA_BYTES = 8,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  fp_pkg::byte_t    rx_data,
    input  logic             rx_valid,
    output logic             rx_ready,
    input  fp_pkg::apb_req_t apb_req,
    output fp_pkg::apb_rsp_t apb_rsp,
    output logic             frame_irq
);

    // FIFO to parser
    fp_pkg::byte_t   fifo_data;
    logic            fifo_empty;
    logic            fifo_rd_en;

    // Parser to registers
    fp_pkg::frame_t  frame;
    logic            frame_valid;
    logic            frame_done;
    fp_pkg::status_t frame_status;
    logic            frame_consume;

    rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (rx_data),
        .wr_valid (rx_valid),
        .wr_ready (rx_ready),
        .rd_data  (fifo_data),
        .rd_en    (fifo_rd_en),
        .empty    (fifo_empty)
    );

    frame_parser #(
        .MAX_DATA_BYTES (MAX_DATA_BYTES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) parser0 (
        .clk           (clk),
        .rst           (rst),
        .fifo_data     (fifo_data),
        .fifo_empty    (fifo_empty),
        .fifo_rd_en    (fifo_rd_en),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .frame_done    (frame_done),
        .frame_status  (frame_status),
        .frame_consume (frame_consume)
    );

    frame_apb_regs regs0 (
        .clk           (clk),
        .rst           (rst),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .frame_done    (frame_done),
        .frame_status  (frame_status),
        .frame_consume (frame_consume),
        .frame_irq     (frame_irq)
    );

endmodule

`default_nettype wire

// ==== frame_rx_checker.sv ====
`default_nettype none

module frame_rx_checker #(
    parameter int MAX_DATA_BYTES = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  fp_pkg::byte_t    rx_data,
    input  logic             rx_valid,
    input  logic             rx_ready,
    input  fp_pkg::apb_req_t apb_req,
    input  fp_pkg::apb_rsp_t apb_rsp,
    output int               errors
);
    timeunit 1ns;
    timeprecision 1ps;

    // Idle cycles mid-frame that mean a cut frame
    localparam int IDLE_LIMIT = 8;

    // ======================================================================
    // Protocol model state
    // ======================================================================

    fp_pkg::frame_t  exp_q[$];
    fp_pkg::frame_t  cur;
    fp_pkg::byte_t   crc;
    fp_pkg::status_t last_status;
    logic [7:0]      err_cnt;
    // 0 idle, 1 cmd, 2 addr, 3 data, 4 crc
    int              mst;
    int              cnt;
    int              idle_cnt;

    // Bit-serial CRC-8 with message bits MSB first
    function automatic fp_pkg::byte_t crc_step(input fp_pkg::byte_t c, input fp_pkg::byte_t b);
        fp_pkg::byte_t r;
        logic          fb;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            fb = r[7] ^ b[i];
            r  = {r[6:0], 1'b0};
            if (fb) begin
                r = r ^ fp_pkg::CRC_POLY;
            end
        end
        return r;
    endfunction

    function automatic logic is_mapped(input logic [7:0] a);
        return a == fp_pkg::REG_STATUS || a == fp_pkg::REG_CMD || a == fp_pkg::REG_ADDR ||
               a == fp_pkg::REG_DATA_LO || a == fp_pkg::REG_DATA_HI ||
               a == fp_pkg::REG_ERR_COUNT || a == fp_pkg::REG_CTRL;
    endfunction

    // Any frame end whether good or bad
    task automatic end_frame(input fp_pkg::status_t s);
        last_status = s;
        if (s != fp_pkg::STATUS_OK && err_cnt != 8'hFF) begin
            err_cnt = err_cnt + 8'd1;
        end
        mst = 0;
    endtask

    task automatic take_byte(input fp_pkg::byte_t b);
        case (mst)
            0: begin
                // Noise before SOF is dropped
                if (b == fp_pkg::SOF_BYTE) begin
                    mst = 1;
                    crc = '0;
                    cur = '0;
                end
            end
            1: begin
                cur.cmd = b;
                crc     = crc_step(crc, b);
                cnt     = 0;
                if (b[7:4] != fp_pkg::OP_READ && b[7:4] != fp_pkg::OP_WRITE) begin
                    end_frame(fp_pkg::STATUS_CMD_INV);
                end else if ((b[7:4] == fp_pkg::OP_READ && b[3:0] != 4'd0) ||
                             int'(b[3:0]) > MAX_DATA_BYTES) begin
                    end_frame(fp_pkg::STATUS_LEN_RANGE);
                end else begin
                    mst = 2;
                end
            end
            2: begin
                cur.addr = {cur.addr[23:0], b};
                crc      = crc_step(crc, b);
                cnt++;
                if (cnt == 4) begin
                    cnt = 0;
                    mst = (cur.cmd[3:0] == 4'd0) ? 4 : 3;
                end
            end
            3: begin
                cur.data[cnt*8 +: 8] = b;
                crc = crc_step(crc, b);
                cnt++;
                if (cnt == int'(cur.cmd[3:0])) begin
                    mst = 4;
                end
            end
            default: begin
                if (b == crc) begin
                    exp_q.push_back(cur);
                    end_frame(fp_pkg::STATUS_OK);
                end else begin
                    end_frame(fp_pkg::STATUS_CRC_ERR);
                end
            end
        endcase
    endtask

    // ======================================================================
    // APB read comparison
    // ======================================================================

    task automatic check_read();
        logic [31:0] exp;
        logic        known;
        logic        held;
        held  = (exp_q.size() != 0);
        known = 1'b1;
        exp   = '0;
        case (apb_req.paddr)
            fp_pkg::REG_STATUS:    exp = {16'h0, last_status, 7'h0, held};
            fp_pkg::REG_ERR_COUNT: exp = {24'h0, err_cnt};
            fp_pkg::REG_CTRL:      exp = '0;
            fp_pkg::REG_CMD: begin
                known = held;
                if (held) exp = {24'h0, exp_q[0].cmd};
            end
            fp_pkg::REG_ADDR: begin
                known = held;
                if (held) exp = exp_q[0].addr;
            end
            fp_pkg::REG_DATA_LO: begin
                known = held;
                if (held) exp = exp_q[0].data[31:0];
            end
            fp_pkg::REG_DATA_HI: begin
                known = held;
                if (held) exp = exp_q[0].data[63:32];
            end
            default: known = 1'b0;
        endcase
        if (known && apb_rsp.prdata != exp) begin
            errors++;
            $display("** Error %0t: read at 0x%02h got 0x%08h, expected 0x%08h",
                     $time, apb_req.paddr, apb_rsp.prdata, exp);
        end
    endtask

    // Sampled on the edge before register updates land
    always @(posedge clk) begin
        if (!rst) begin
            mst         = 0;
            cnt         = 0;
            idle_cnt    = 0;
            err_cnt     = '0;
            last_status = fp_pkg::STATUS_OK;
            errors      = 0;
            exp_q.delete();
        end else begin
            if (rx_valid && rx_ready) begin
                take_byte(rx_data);
                idle_cnt = 0;
            end else if (!rx_valid) begin
                idle_cnt++;
                if (mst != 0 && idle_cnt == IDLE_LIMIT) begin
                    end_frame(fp_pkg::STATUS_TIMEOUT);
                end
            end
            if (apb_req.psel && apb_req.penable) begin
                // No wait states on this bus
                if (!apb_rsp.pready) begin
                    errors++;
                    $display("** Error %0t: pready low at offset 0x%02h",
                             $time, apb_req.paddr);
                end
                if (apb_rsp.pslverr != !is_mapped(apb_req.paddr)) begin
                    errors++;
                    $display("** Error %0t: pslverr %0b at offset 0x%02h",
                             $time, apb_rsp.pslverr, apb_req.paddr);
                end
                if (apb_req.pwrite) begin
                    // Consume pops the held frame
                    if (apb_req.paddr == fp_pkg::REG_CTRL && apb_req.pwdata[0] &&
                        exp_q.size() != 0) begin
                        void'(exp_q.pop_front());
                    end
                end else begin
                    check_read();
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_frame_rx.sv ====
`default_nettype none

module tb_frame_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH     = 16;
    localparam int MAX_DATA_BYTES = 8;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int MAIN_FRAMES    = 30;
    localparam int BP_FRAMES      = 6;
    localparam int STALL_CYCLES   = 300;
    localparam int CYCLE_LIMIT    = (MAIN_FRAMES + BP_FRAMES) * 200;

    logic             clk = 1'b0;
    logic             rst;
    fp_pkg::byte_t    rx_data;
    logic             rx_valid;
    logic             rx_ready;
    fp_pkg::apb_req_t apb_req;
    fp_pkg::apb_rsp_t apb_rsp;
    logic             frame_irq;

    int               chk_errors;
    int               tb_errors = 0;
    int               cycles = 0;
    logic [31:0]      lcg_state = 32'hd594_272c;
    fp_pkg::byte_t    frame_bytes[$];
    logic             watch_stall = 1'b0;
    logic             stall_seen = 1'b0;

    always #5 clk = ~clk;

    frame_rx_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .MAX_DATA_BYTES (MAX_DATA_BYTES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .frame_irq (frame_irq)
    );

    frame_rx_checker #(
        .MAX_DATA_BYTES (MAX_DATA_BYTES)
    ) chk0 (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .errors   (chk_errors)
    );

    // Watchdog and stall monitor
    always @(posedge clk) begin
        cycles++;
        if (watch_stall && !rx_ready) begin
            stall_seen <= 1'b1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ======================================================================
    // Random numbers and CRC
    // ======================================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rnd_below(input int n);
        return int'(lcg_next() >> 8) % n;
    endfunction

    function automatic fp_pkg::byte_t crc_byte(input fp_pkg::byte_t c, input fp_pkg::byte_t b);
        fp_pkg::byte_t r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            r = (r[7] ^ b[i]) ? ({r[6:0], 1'b0} ^ fp_pkg::CRC_POLY) : {r[6:0], 1'b0};
        end
        return r;
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Holds the byte until the FIFO takes it
    task automatic put_byte(input fp_pkg::byte_t b);
        logic taken;
        rx_data  = b;
        rx_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            taken = rx_ready;
            tick();
        end
        rx_valid = 1'b0;
    endtask

    // Kinds 0 good, 1 bad CRC, 2 bad opcode, 3 bad length, 4 cut frame
    task automatic build_frame(input int kind);
        logic [3:0]    op;
        logic [3:0]    len;
        fp_pkg::byte_t crc;
        int            cut;
        frame_bytes.delete();
        op  = (rnd_below(2) == 0) ? fp_pkg::OP_READ : fp_pkg::OP_WRITE;
        len = (op == fp_pkg::OP_READ) ? 4'd0 : 4'(rnd_below(MAX_DATA_BYTES + 1));
        if (kind == 2) begin
            // 0 or 3..15
            op = 4'(rnd_below(14));
            if (op >= 4'd1) op = op + 4'd2;
            len = 4'(rnd_below(16));
        end else if (kind == 3) begin
            if (rnd_below(2) == 0) begin
                op  = fp_pkg::OP_READ;
                len = 4'(1 + rnd_below(15));
            end else begin
                op  = fp_pkg::OP_WRITE;
                len = 4'(MAX_DATA_BYTES + 1 + rnd_below(15 - MAX_DATA_BYTES));
            end
        end
        frame_bytes.push_back(fp_pkg::SOF_BYTE);
        frame_bytes.push_back({op, len});
        if (kind == 2 || kind == 3) return;
        repeat (4 + int'(len)) frame_bytes.push_back(8'(lcg_next()));
        crc = '0;
        for (int i = 1; i < frame_bytes.size(); i++) begin
            crc = crc_byte(crc, frame_bytes[i]);
        end
        if (kind == 1) crc = crc ^ 8'(1 + rnd_below(255));
        frame_bytes.push_back(crc);
        if (kind == 4) begin
            cut = 1 + rnd_below(frame_bytes.size() - 1);
            while (frame_bytes.size() > cut) void'(frame_bytes.pop_back());
        end
    endtask

    // Filler first, short gaps inside, none after the last byte
    task automatic send_frame();
        fp_pkg::byte_t f;
        repeat (rnd_below(3)) begin
            f = 8'(lcg_next());
            if (f == fp_pkg::SOF_BYTE) f = 8'h55;
            put_byte(f);
        end
        foreach (frame_bytes[i]) begin
            put_byte(frame_bytes[i]);
            if (i < frame_bytes.size() - 1) repeat (rnd_below(4)) tick();
        end
    endtask

    // ======================================================================
    // APB host
    // ======================================================================

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wd);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wd};
        tick();
        apb_req.penable = 1'b1;
        tick();
        apb_req = '0;
    endtask

    task automatic read_good_frame();
        while (!frame_irq) tick();
        apb_access(1'b0, fp_pkg::REG_STATUS, '0);
        apb_access(1'b0, fp_pkg::REG_CMD, '0);
        apb_access(1'b0, fp_pkg::REG_ADDR, '0);
        apb_access(1'b0, fp_pkg::REG_DATA_LO, '0);
        apb_access(1'b0, fp_pkg::REG_DATA_HI, '0);
        apb_access(1'b0, fp_pkg::REG_ERR_COUNT, '0);
        apb_access(1'b1, fp_pkg::REG_CTRL, 32'h1);
        // Let the parser drop back to IDLE
        repeat (2) tick();
    endtask

    task automatic read_bad_frame();
        repeat (2) tick();
        if (frame_irq) begin
            tb_errors++;
            $display("** Error %0t: frame_irq high after a bad frame", $time);
        end
        apb_access(1'b0, fp_pkg::REG_STATUS, '0);
        apb_access(1'b0, fp_pkg::REG_ERR_COUNT, '0);
    endtask

    initial begin
        int kind;
        int pick;
        rst      = 1'b0;
        rx_data  = '0;
        rx_valid = 1'b0;
        apb_req  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        tick();

        // Unmapped offsets and a consume with nothing held
        apb_access(1'b0, 8'h1C, '0);
        apb_access(1'b1, 8'h20, 32'h1);
        apb_access(1'b1, fp_pkg::REG_CTRL, 32'h1);
        apb_access(1'b0, fp_pkg::REG_STATUS, '0);
        apb_access(1'b0, fp_pkg::REG_ERR_COUNT, '0);

        for (int i = 0; i < MAIN_FRAMES; i++) begin
            pick = rnd_below(10);
            kind = (pick < 5) ? 0 : (pick < 7) ? 1 : pick - 5;
            if (i < 5) kind = i;
            build_frame(kind);
            send_frame();
            if (kind == 0) begin
                read_good_frame();
            end else begin
                while (!dut0.frame_done) tick();
                // Cut frames keep the line silent well past the limit
                if (kind == 4) repeat (FIFO_DEPTH + 4) tick();
                read_bad_frame();
            end
        end

        // Back-pressure with a slow host
        watch_stall = 1'b1;
        fork
            begin
                for (int i = 0; i < BP_FRAMES; i++) begin
                    build_frame(0);
                    send_frame();
                end
            end
            begin
                repeat (STALL_CYCLES) tick();
                repeat (BP_FRAMES) read_good_frame();
            end
        join
        if (!stall_seen) begin
            tb_errors++;
            $display("Back-pressure test failed: rx_ready never fell during the stall");
        end

        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
fp_pkg.sv
rx_fifo.sv
frame_parser.sv
frame_apb_regs.sv
frame_rx_top.sv
frame_rx_checker.sv
tb_frame_rx.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

# Build the testbench with the DUT
verilator --binary -j 0 --top-module tb_frame_rx -f list.f

# Run, then decide on the pass line
out=$(./obj_dir/Vtb_frame_rx)
echo "$out"
if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
